// File: verilog.f
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_ctrl.sv
tests/eeprom_model.sv
tests/eeprom_ctrl_sva.sv
tests/tb_eeprom_ctrl.sv

// File: tests/tb_eeprom_ctrl.sv
`default_nettype none

module tb_eeprom_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SCL_DIV  = 2;
    localparam int unsigned SHORT_OP = 4 * SCL_DIV;     // start or stop
    localparam int unsigned BYTE_OP  = 36 * SCL_DIV;
    // one extra sequencer cycle per command
    localparam int unsigned WRITE_CYCLES   = 2 * SHORT_OP + 3 * BYTE_OP + 5;
    localparam int unsigned READ_CYCLES    = 3 * SHORT_OP + 4 * BYTE_OP + 7;
    localparam int unsigned N_REQUESTS     = 40;
    localparam int unsigned TIMEOUT_CYCLES =
        N_REQUESTS * (READ_CYCLES + 4) + 2 * WRITE_CYCLES + 500;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        ack;
    logic        nack;
    logic        scl;
    wire         sda;
    logic        ack_en;

    logic [7:0]  shadow [0:2047];
    logic [31:0] rng;
    int unsigned cycle_count;
    int unsigned ack_count;
    int unsigned req_count;
    string       cur_test;
    logic        exp_is_read;
    logic [7:0]  exp_byte;
    logic        exp_nack;

    always #5 CLK = ~CLK;

    pullup (sda);

    eeprom_ctrl #(
        .SCL_DIV (SCL_DIV)
    ) eeprom_ctrl_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .nack    (nack),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model eeprom_model_i (
        .scl    (scl),
        .sda    (sda),
        .ack_en (ack_en)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] expected_read(input logic [10:0] a);
        return shadow[a];
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("** Error %s rd_data: expected %02h, actual %02h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("** Error %s nack: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    task automatic check_ack_count(input string name);
        if (ack_count != req_count)
        begin
            stop_with_failure($sformatf("%s: saw %0d acks for %0d requests",
                                        name, ack_count, req_count));
        end
    endtask

    // one-cycle strobe with the expectations set first
    task automatic send_request(input string name, input logic is_read, input logic [10:0] a,
                                input logic [7:0] d, input logic exp_n);
        check_ack_count(name);
        cur_test    = name;
        exp_is_read = is_read;
        exp_nack    = exp_n;
        exp_byte    = expected_read(a);
        if (!is_read && !exp_n)
        begin
            shadow[a] = d;
        end
        wr      = ~is_read;
        rd      = is_read;
        addr    = a;
        wr_data = d;
        req_count++;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_for_ack();
        while (ack_count != req_count)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic run_request(input string name, input logic is_read, input logic [10:0] a,
                               input logic [7:0] d, input logic exp_n);
        send_request(name, is_read, a, d, exp_n);
        wait_for_ack();
        repeat (2) @(posedge CLK);    // room for a stray second ack
        #1;
    endtask

    // compare at each ack
    always @(posedge CLK)
    begin
        if (!RESET && (ack === 1'b1))
        begin
            ack_count = ack_count + 1;
            check_flag(cur_test, exp_nack, nack);
            if (exp_is_read && !exp_nack)
            begin
                check_data(cur_test, exp_byte, rd_data);
            end
        end
    end

    always @(posedge CLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_with_failure("timeout: the requests did not finish within the cycle limit");
        end
    end

    initial
    begin
        int          i;
        int          idx;
        logic [10:0] a;
        logic        is_rd;
        logic [10:0] last_wr;
        logic        have_written;

        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wr_data      = 8'h00;
        ack_en       = 1'b1;
        rng          = 32'd98;
        cycle_count  = 0;
        ack_count    = 0;
        req_count    = 0;
        cur_test     = "reset";
        exp_is_read  = 1'b0;
        exp_byte     = 8'h00;
        exp_nack     = 1'b0;
        last_wr      = '0;
        have_written = 1'b0;
        for (idx = 0; idx < 2048; idx++)
        begin
            shadow[idx] = 8'(idx) ^ 8'h5A;   // same rule as the model
        end

        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        // idle bus after reset
        if (scl !== 1'b1)
        begin
            stop_with_failure("scl is not high after reset");
        end
        if (sda !== 1'b1)
        begin
            stop_with_failure("sda is not released after reset");
        end
        if (ack !== 1'b0)
        begin
            stop_with_failure("ack is not low after reset");
        end

        run_request("write_then_read_wr", 1'b0, 11'h123, 8'hA7, 1'b0);
        run_request("write_then_read_rd", 1'b1, 11'h123, 8'h00, 1'b0);
        run_request("read_unwritten", 1'b1, 11'h6C3, 8'h00, 1'b0);

        for (i = 0; i < 30; i++)
        begin
            rng = xorshift(rng);
            if ((i >= 8) && have_written && rng[12])
            begin
                a = last_wr;
            end
            else
            begin
                a = {3'(i), rng[7:0]};   // first eight hit every block
            end
            is_rd = rng[20];
            if (!is_rd)
            begin
                last_wr      = a;
                have_written = 1'b1;
            end
            run_request($sformatf("random_%0d", i), is_rd, a, rng[31:24], 1'b0);
        end

        ack_en = 1'b0;
        run_request("write_no_ack", 1'b0, 11'h5E1, 8'h3C, 1'b1);
        run_request("read_no_ack", 1'b1, 11'h5E1, 8'h00, 1'b1);
        ack_en = 1'b1;
        run_request("read_after_failed_write", 1'b1, 11'h5E1, 8'h00, 1'b0);

        // wr strobe in the middle of a read
        send_request("read_with_wr_strobe", 1'b1, 11'h2B4, 8'h00, 1'b0);
        repeat (4) @(posedge CLK);
        #1;
        wr      = 1'b1;
        addr    = 11'h2B5;
        wr_data = 8'hC3;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        wait_for_ack();
        repeat (WRITE_CYCLES + 10) @(posedge CLK);
        #1;
        check_ack_count("read_with_wr_strobe");
        run_request("ignored_write_unchanged", 1'b1, 11'h2B5, 8'h00, 1'b0);

        check_ack_count("end");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/eeprom_ctrl_sva.sv
`default_nettype none

module eeprom_ctrl_sva
    import eeprom_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  logic    ack,
    input  logic    scl,
    input  wire     sda,
    input  logic    eng_active,
    input  bus_op_t eng_op
);
    timeunit 1ns;
    timeprecision 100ps;

    logic edge_op;    // start or stop running in the bit engine

    assign edge_op = eng_active && ((eng_op == op_start) || (eng_op == op_stop));

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack stayed high for two cycles");

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !edge_op) |-> $stable(sda))
        else $error("sda changed while scl was high outside a start or stop");

    ack_low_in_reset: assert property (@(posedge CLK) RESET |=> !ack)
        else $error("ack not low during reset");

endmodule

bind eeprom_ctrl eeprom_ctrl_sva eeprom_ctrl_sva_i (
    .CLK        (CLK),
    .RESET      (RESET),
    .ack        (ack),
    .scl        (scl),
    .sda        (sda),
    .eng_active (i2c_bit_engine_i.active),
    .eng_op     (i2c_bit_engine_i.op_q)
);

`default_nettype wire

// File: tests/eeprom_model.sv
`default_nettype none

module eeprom_model
    import eeprom_pkg::*;
(
    input  wire scl,
    inout  wire sda,
    input  wire ack_en
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SEL,
        PH_ADDR,
        PH_WDATA,
        PH_RDATA
    } phase_t;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    phase_t      phase;
    phase_t      next_phase;
    logic [3:0]  cnt;          // scl rising edges in this byte with 9 for the ack slot
    logic [7:0]  rx;
    logic [7:0]  tx;
    logic        ack_slot;
    logic        drive_low;
    int          idx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (idx = 0; idx < 2048; idx++)
        begin
            mem[idx] = 8'(idx) ^ 8'h5A;
        end
        ptr        = '0;
        phase      = PH_IDLE;
        next_phase = PH_IDLE;
        cnt        = 4'd0;
        rx         = 8'h00;
        tx         = 8'h00;
        ack_slot   = 1'b0;
        drive_low  = 1'b0;
    end

    // decide what to do with a completed byte from the master
    task automatic accept_byte();
        case (phase)
            PH_SEL:
            begin
                ack_slot = ack_en && (rx[7:4] == dev_code);
                if (!ack_slot)
                begin
                    next_phase = PH_IDLE;
                end
                else
                begin
                    ptr        = {rx[3:1], ptr[7:0]};   // block bits
                    next_phase = rx[0] ? PH_RDATA : PH_ADDR;
                end
            end
            PH_ADDR:
            begin
                ptr        = {ptr[10:8], rx};
                ack_slot   = 1'b1;
                next_phase = PH_WDATA;
            end
            PH_WDATA:
            begin
                mem[ptr]   = rx;
                ptr        = ptr + 11'd1;
                ack_slot   = 1'b1;
                next_phase = PH_WDATA;
            end
            default:
            begin
                ack_slot   = 1'b0;
                next_phase = phase;
            end
        endcase
    endtask

    // start when sda falls with scl high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase     = PH_SEL;
            cnt       = 4'd0;
            drive_low = 1'b0;
        end
    end

    // stop when sda rises with scl high
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase     = PH_IDLE;
            cnt       = 4'd0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != PH_IDLE)
        begin
            cnt = cnt + 4'd1;
            if (cnt <= 4'd8)
            begin
                rx = {rx[6:0], sda};
            end
            if (cnt == 4'd8)
            begin
                accept_byte();
            end
            else if (cnt == 4'd9)
            begin
                if (phase == PH_RDATA)
                begin
                    ptr        = ptr + 11'd1;
                    next_phase = (sda === 1'b0) ? PH_RDATA : PH_IDLE;   // master nack ends it
                end
                phase = next_phase;
                if (phase == PH_RDATA)
                begin
                    tx = mem[ptr];
                end
            end
        end
    end

    // slave changes sda only while scl is low
    always @(negedge scl)
    begin
        if (cnt == 4'd9)
        begin
            cnt = 4'd0;
        end
        if ((phase == PH_RDATA) && (cnt < 4'd8))
        begin
            drive_low = ~tx[7 - cnt];
        end
        else if ((cnt == 4'd8) && (phase != PH_RDATA))
        begin
            drive_low = ack_slot;
        end
        else
        begin
            drive_low = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl
    import eeprom_pkg::*;
#(
    parameter int unsigned SCL_DIV = 2
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    output logic [7:0]  rd_data,
    output logic        ack,
    output logic        nack,
    output logic        scl,
    inout  wire         sda
);

    eeprom_req_t req;
    logic        start;
    logic        busy;
    logic        cmd_valid;
    bus_cmd_t    cmd;
    logic        done;
    bus_res_t    res;
    logic        sda_low;
    logic        sda_in;

    // wr wins when both strobes are high
    assign req   = '{is_read: rd & ~wr, addr: addr, data: wr_data};
    assign start = (wr | rd) & ~busy;     // strobes while busy are dropped

    // open drain pad with an external pull-up
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_sequencer eeprom_sequencer_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .req       (req),
        .busy      (busy),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .res       (res),
        .rd_data   (rd_data),
        .ack       (ack),
        .nack      (nack)
    );

    i2c_bit_engine #(
        .SCL_DIV (SCL_DIV)
    ) i2c_bit_engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .res       (res),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

// File: design/eeprom_sequencer.sv
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        start,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        cmd_valid,
    output bus_cmd_t    cmd,
    input  logic        done,
    input  bus_res_t    res,
    output logic [7:0]  rd_data,
    output logic        ack,
    output logic        nack
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } seq_state_t;

    seq_state_t  state;
    eeprom_req_t req_q;
    logic [2:0]  step;
    logic [2:0]  last_step;    // index of the closing stop
    logic        nack_acc;

    // command list
    // write sends start, sel(w), addr, data, stop
    // read sends start, sel(w), addr, start, sel(r), read with nack, stop
    function automatic bus_cmd_t step_cmd(input logic [2:0] idx, input eeprom_req_t r);
        bus_cmd_t   c;
        logic [7:0] sel;
        sel    = {dev_code, r.addr[10:8], 1'b0};
        c.op   = op_write;
        c.data = 8'h00;
        c.last = 1'b0;
        case (idx)
            3'd0: c.op = op_start;
            3'd1: c.data = sel;
            3'd2: c.data = r.addr[7:0];
            3'd3:
            begin
                if (r.is_read)
                begin
                    c.op = op_start;     // repeated start
                end
                else
                begin
                    c.data = r.data;
                end
            end
            3'd4:
            begin
                if (r.is_read)
                begin
                    c.data = sel | 8'h01;   // direction bit set
                end
                else
                begin
                    c.op = op_stop;
                end
            end
            3'd5:
            begin
                c.op   = op_read;
                c.last = 1'b1;
            end
            default: c.op = op_stop;
        endcase
        return c;
    endfunction

    assign busy      = (state == ST_RUN);
    assign last_step = req_q.is_read ? 3'd6 : 3'd4;
    assign cmd       = step_cmd(step, req_q);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            step      <= 3'd0;
            nack_acc  <= 1'b0;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
            rd_data   <= 8'h00;
        end
        else
        begin
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state     <= ST_RUN;
                        step      <= 3'd0;
                        nack_acc  <= 1'b0;
                        cmd_valid <= 1'b1;
                    end
                end
                default:
                begin
                    if (done)
                    begin
                        if (step == last_step)
                        begin
                            state   <= ST_IDLE;
                            ack     <= 1'b1;
                            nack    <= nack_acc;
                            rd_data <= res.data;    // read byte survives the stop
                        end
                        else
                        begin
                            nack_acc  <= nack_acc | res.no_ack;
                            // on a nack go straight to the stop
                            step      <= res.no_ack ? last_step : step + 3'd1;
                            cmd_valid <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == ST_IDLE) && start)
        begin
            req_q <= req;
        end
    end

endmodule

`default_nettype wire

// File: design/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int unsigned SCL_DIV = 2    // CLK cycles per quarter of an SCL period
)
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bus_cmd_t cmd,
    output logic     done,
    output bus_res_t res,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    localparam int unsigned DIV_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       qtr;        // quarter inside the current bit
    logic [3:0]       bit_cnt;    // 0..8 for bytes, 0 for start/stop
    logic             quarter_end;
    logic             last_bit;
    logic             is_byte;

    bus_op_t          op_q;
    logic             last_q;
    logic [7:0]       shreg;      // tx byte shifts out while rx bits shift in
    logic             sda_smp;    // SDA taken at the end of the second quarter

    // bus levels held while no command runs
    logic             scl_q;
    logic             sda_low_q;

    logic             drive_bit;

    assign quarter_end = (div_cnt == DIV_W'(SCL_DIV - 1));
    assign is_byte     = (op_q == op_write) || (op_q == op_read);
    assign last_bit    = is_byte ? (bit_cnt == 4'd8) : (bit_cnt == 4'd0);
    assign done        = active && quarter_end && (qtr == 2'd3) && last_bit;

    assign res = '{data: shreg, no_ack: (op_q == op_write) & sda_smp};

    // SDA level wanted during a data or ack bit
    always_comb
    begin
        if (bit_cnt < 4'd8)
        begin
            drive_bit = (op_q == op_write) ? ~shreg[7] : 1'b0;
        end
        else
        begin
            drive_bit = (op_q == op_read) ? ~last_q : 1'b0;   // master ack unless last
        end
    end

    always_comb
    begin
        if (!active)
        begin
            scl     = scl_q;
            sda_low = sda_low_q;
        end
        else
        begin
            case (op_q)
                op_start:
                begin
                    scl     = (qtr == 2'd1) || (qtr == 2'd2);
                    sda_low = (qtr >= 2'd2);       // falls with SCL high
                end
                op_stop:
                begin
                    scl     = (qtr != 2'd0);
                    sda_low = (qtr <= 2'd1);       // rises with SCL high
                end
                default:
                begin
                    scl     = (qtr == 2'd1) || (qtr == 2'd2);
                    sda_low = drive_bit;
                end
            endcase
        end
    end

    // control state
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            div_cnt   <= '0;
            qtr       <= 2'd0;
            bit_cnt   <= 4'd0;
            scl_q     <= 1'b1;
            sda_low_q <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_valid)
            begin
                active  <= 1'b1;
                div_cnt <= '0;
                qtr     <= 2'd0;
                bit_cnt <= 4'd0;
            end
        end
        else
        begin
            if (quarter_end)
            begin
                div_cnt <= '0;
                qtr     <= qtr + 2'd1;
                if (qtr == 2'd3)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else
            begin
                div_cnt <= div_cnt + DIV_W'(1);
            end

            if (done)
            begin
                active    <= 1'b0;
                scl_q     <= scl;        // low after start or byte, high after stop
                sda_low_q <= sda_low;
            end
        end
    end

    // command payload and shifter
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            op_q   <= cmd.op;
            last_q <= cmd.last;
            if ((cmd.op == op_write) || (cmd.op == op_read))
            begin
                shreg <= cmd.data;       // kept through a stop
            end
        end

        if (active && quarter_end)
        begin
            if (qtr == 2'd1)
            begin
                sda_smp <= sda_in;
            end
            if ((qtr == 2'd3) && is_byte && (bit_cnt < 4'd8))
            begin
                shreg <= {shreg[6:0], sda_smp};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // device type code, top nibble of every select byte
    localparam logic [3:0] dev_code = 4'b1010;

    // one user request
    typedef struct packed {
        logic        is_read;
        logic [10:0] addr;     // bits 10:8 go into the select byte
        logic [7:0]  data;     // write data, unused on reads
    } eeprom_req_t;

    // bit engine opcodes
    // a start on a busy bus acts as a repeated start
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } bus_op_t;

    // command from sequencer to bit engine
    typedef struct packed {
        bus_op_t    op;
        logic [7:0] data;      // byte to send on op_write
        logic       last;      // nack the byte on op_read
    } bus_cmd_t;

    // result returned with done
    typedef struct packed {
        logic [7:0] data;      // shifter contents and the received byte after op_read
        logic       no_ack;    // slave left the ack slot high, op_write only
    } bus_res_t;

endpackage

`default_nettype wire
